/* source/isa_pkg.sv */
package isa_pkg;

    // ------------------------------------------------------------------------
    // Architectural widths
    // ------------------------------------------------------------------------
    localparam int unsigned XLen = 32;

    // Address space of the control and status registers
    localparam int unsigned CsrAddrWidth = 12;

    // ------------------------------------------------------------------------
    // Functional unit operations
    // ------------------------------------------------------------------------
    typedef enum logic [4:0] {
        // Arithmetic, logic, shifts and set-less-than
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLTS,
        SLTU,
        // Conditional branch comparisons
        EQ,
        NE,
        LTS,
        GES,
        LTU,
        GEU,
        // Unconditional jumps
        JAL,
        JALR,
        // CSR access
        CSR_READ,
        CSR_WRITE,
        // Multiplication, low word and the two high-word variants
        MUL,
        MULH,
        MULHU
    } fu_op_e;

endpackage

/* source/ex_pkg.sv */
package ex_pkg;

    // Scoreboard entry index carried with every instruction
    localparam int unsigned TransIdBits = 3;

    // ------------------------------------------------------------------------
    // Issue side
    // ------------------------------------------------------------------------
    // One instruction as handed over by the issue stage
    typedef struct packed {
        isa_pkg::fu_op_e                 operation;
        logic [isa_pkg::XLen-1:0]        operand_a;
        logic [isa_pkg::XLen-1:0]        operand_b;
        logic [isa_pkg::XLen-1:0]        imm;
        logic [TransIdBits-1:0]          trans_id;
    } fu_data_t;

    // Prediction made by the front end for a control-flow instruction
    typedef struct packed {
        logic                            cf_taken;
        logic [isa_pkg::XLen-1:0]        predict_address;
    } branch_predict_t;

    // ------------------------------------------------------------------------
    // Result side
    // ------------------------------------------------------------------------
    // Outcome of a resolved branch or jump, sent back to the front end
    typedef struct packed {
        logic                            valid;
        logic [isa_pkg::XLen-1:0]        pc;
        logic [isa_pkg::XLen-1:0]        target_address;
        logic                            is_taken;
        logic                            is_mispredict;
    } bp_resolve_t;

    // Shared write-back port into the scoreboard
    typedef struct packed {
        logic                            valid;
        logic [TransIdBits-1:0]          trans_id;
        logic [isa_pkg::XLen-1:0]        result;
    } flu_wb_t;

endpackage

/* source/alu.sv */
`timescale 1ns/10ps

module alu (
    input  ex_pkg::fu_data_t          fu_data_i,
    output logic [isa_pkg::XLen-1:0]  result_o,
    output logic                      branch_cmp_res_o
);

    localparam int unsigned ShamtBits = $clog2(isa_pkg::XLen);

    logic                      adder_negate;
    logic [isa_pkg::XLen-1:0]  adder_op_b;
    logic [isa_pkg::XLen:0]    adder_sum;
    logic [isa_pkg::XLen-1:0]  adder_result;
    logic                      adder_zero;
    logic                      less_unsigned;
    logic                      less_signed;
    logic                      less;
    logic [ShamtBits-1:0]      shamt;

    // ------------------------------------------------------------------------
    // Shared adder, subtracts for SUB and all comparisons
    // ------------------------------------------------------------------------
    assign adder_negate = fu_data_i.operation inside {isa_pkg::SUB, isa_pkg::SLTS,
        isa_pkg::SLTU, isa_pkg::EQ, isa_pkg::NE, isa_pkg::LTS, isa_pkg::GES,
        isa_pkg::LTU, isa_pkg::GEU};

    assign adder_op_b   = fu_data_i.operand_b ^ {isa_pkg::XLen{adder_negate}};
    assign adder_sum    = {1'b0, fu_data_i.operand_a} + {1'b0, adder_op_b}
                        + {{isa_pkg::XLen{1'b0}}, adder_negate};
    assign adder_result = adder_sum[isa_pkg::XLen-1:0];
    assign adder_zero   = ~|adder_result;

    // No carry out of a + ~b + 1 means a < b unsigned
    assign less_unsigned = ~adder_sum[isa_pkg::XLen];
    // Differing signs decide directly, otherwise the difference sign does
    assign less_signed = (fu_data_i.operand_a[isa_pkg::XLen-1] ^ fu_data_i.operand_b[isa_pkg::XLen-1])
                       ? fu_data_i.operand_a[isa_pkg::XLen-1]
                       : adder_result[isa_pkg::XLen-1];

    assign less = (fu_data_i.operation inside {isa_pkg::SLTS, isa_pkg::LTS, isa_pkg::GES})
                ? less_signed : less_unsigned;

    assign shamt = fu_data_i.operand_b[ShamtBits-1:0];

    // Branch condition
    always_comb begin
        unique case (fu_data_i.operation)
            isa_pkg::EQ:               branch_cmp_res_o = adder_zero;
            isa_pkg::NE:               branch_cmp_res_o = ~adder_zero;
            isa_pkg::LTS, isa_pkg::LTU: branch_cmp_res_o = less;
            isa_pkg::GES, isa_pkg::GEU: branch_cmp_res_o = ~less;
            default:                   branch_cmp_res_o = 1'b0;
        endcase
    end

    // Result select
    always_comb begin
        unique case (fu_data_i.operation)
            isa_pkg::ADD, isa_pkg::SUB: result_o = adder_result;
            isa_pkg::AND:  result_o = fu_data_i.operand_a & fu_data_i.operand_b;
            isa_pkg::OR:   result_o = fu_data_i.operand_a | fu_data_i.operand_b;
            isa_pkg::XOR:  result_o = fu_data_i.operand_a ^ fu_data_i.operand_b;
            isa_pkg::SLL:  result_o = fu_data_i.operand_a << shamt;
            isa_pkg::SRL:  result_o = fu_data_i.operand_a >> shamt;
            isa_pkg::SRA:  result_o = $unsigned($signed(fu_data_i.operand_a) >>> shamt);
            isa_pkg::SLTS, isa_pkg::SLTU: result_o = {{(isa_pkg::XLen-1){1'b0}}, less};
            default:       result_o = '0;
        endcase
    end

endmodule

/* source/branch_unit.sv */
`timescale 1ns/10ps

module branch_unit (
    input  ex_pkg::fu_data_t          fu_data_i,
    input  logic [isa_pkg::XLen-1:0]  pc_i,
    input  logic                      is_compressed_i,
    input  logic                      branch_valid_i,
    input  ex_pkg::branch_predict_t   branch_predict_i,
    input  logic                      branch_cmp_res_i,
    output logic [isa_pkg::XLen-1:0]  link_addr_o,
    output ex_pkg::bp_resolve_t       resolved_branch_o
);

    logic                      is_jump;
    logic                      is_jalr;
    logic [isa_pkg::XLen-1:0]  target_base;
    logic [isa_pkg::XLen-1:0]  target_sum;
    logic [isa_pkg::XLen-1:0]  jump_target;
    logic [isa_pkg::XLen-1:0]  next_pc;
    logic                      taken;
    logic                      dir_wrong;
    logic                      target_wrong;

    // ------------------------------------------------------------------------
    // Target and fall-through addresses
    // ------------------------------------------------------------------------
    assign is_jalr = (fu_data_i.operation == isa_pkg::JALR);
    assign is_jump = is_jalr || (fu_data_i.operation == isa_pkg::JAL);

    // Register-relative only for JALR, PC-relative otherwise
    assign target_base = is_jalr ? fu_data_i.operand_a : pc_i;
    assign target_sum  = target_base + fu_data_i.imm;

    // JALR clears the lowest target bit
    assign jump_target = {target_sum[isa_pkg::XLen-1:1], target_sum[0] & ~is_jalr};

    // Next sequential instruction, also the link value
    assign next_pc     = pc_i + (is_compressed_i ? isa_pkg::XLen'(2) : isa_pkg::XLen'(4));
    assign link_addr_o = next_pc;

    // ------------------------------------------------------------------------
    // Resolution against the prediction
    // ------------------------------------------------------------------------
    assign taken = is_jump | branch_cmp_res_i;

    assign dir_wrong    = taken != branch_predict_i.cf_taken;
    assign target_wrong = taken && (jump_target != branch_predict_i.predict_address);

    always_comb begin
        resolved_branch_o.valid          = branch_valid_i;
        resolved_branch_o.pc             = pc_i;
        resolved_branch_o.is_taken       = taken;
        // Not taken reports where execution really continues
        resolved_branch_o.target_address = taken ? jump_target : next_pc;
        resolved_branch_o.is_mispredict  = branch_valid_i & (dir_wrong | target_wrong);
    end

endmodule

/* source/csr_buffer.sv */
`timescale 1ns/10ps

module csr_buffer (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    input  logic                              csr_valid_i,
    input  logic                              csr_commit_i,
    input  ex_pkg::fu_data_t                  fu_data_i,
    output logic                              csr_ready_o,
    output logic [isa_pkg::XLen-1:0]          csr_result_o,
    output logic [isa_pkg::CsrAddrWidth-1:0]  csr_addr_o
);

    logic                              full_q;
    logic [isa_pkg::CsrAddrWidth-1:0]  addr_q;

    // Write data goes straight back, the CSR file is accessed at commit
    assign csr_result_o = fu_data_i.operand_a;
    assign csr_addr_o   = addr_q;

    // One entry only, so a held address blocks further issue
    assign csr_ready_o  = ~full_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
            addr_q <= '0;
        end else begin
            if (flush_i) begin
                full_q <= 1'b0;
            end else if (csr_valid_i) begin
                full_q <= 1'b1;
                addr_q <= fu_data_i.operand_b[isa_pkg::CsrAddrWidth-1:0];
            end else if (csr_commit_i) begin
                // Retired, the entry is free again
                full_q <= 1'b0;
            end
        end
    end

endmodule

/* source/mult.sv */
`timescale 1ns/10ps

module mult (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    input  logic                              mult_valid_i,
    input  ex_pkg::fu_data_t                  fu_data_i,
    output logic [isa_pkg::XLen-1:0]          result_o,
    output logic                              mult_valid_o,
    output logic [ex_pkg::TransIdBits-1:0]    mult_trans_id_o
);

    logic                                  sign_ext;
    logic signed [isa_pkg::XLen:0]         op_a_ext;
    logic signed [isa_pkg::XLen:0]         op_b_ext;
    logic signed [2*isa_pkg::XLen-1:0]     product;
    logic [isa_pkg::XLen-1:0]              result_d;
    logic [isa_pkg::XLen-1:0]              result_q;
    logic                                  valid_q;
    logic [ex_pkg::TransIdBits-1:0]        trans_id_q;

    // ------------------------------------------------------------------------
    // Product
    // ------------------------------------------------------------------------
    // One extra bit makes MULH and MULHU share a signed multiplier
    assign sign_ext = (fu_data_i.operation == isa_pkg::MULH);
    assign op_a_ext = {sign_ext & fu_data_i.operand_a[isa_pkg::XLen-1], fu_data_i.operand_a};
    assign op_b_ext = {sign_ext & fu_data_i.operand_b[isa_pkg::XLen-1], fu_data_i.operand_b};
    assign product  = op_a_ext * op_b_ext;

    always_comb begin
        unique case (fu_data_i.operation)
            isa_pkg::MULH, isa_pkg::MULHU: result_d = product[2*isa_pkg::XLen-1:isa_pkg::XLen];
            default:                       result_d = product[isa_pkg::XLen-1:0];
        endcase
    end

    // ------------------------------------------------------------------------
    // Output stage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        result_q   <= result_d;
        trans_id_q <= fu_data_i.trans_id;
    end

    // A flush one cycle after issue kills the pending result
    assign mult_valid_o    = valid_q & ~flush_i;
    assign result_o        = result_q;
    assign mult_trans_id_o = trans_id_q;

endmodule

/* source/ex_stage.sv */
`timescale 1ns/10ps

module ex_stage (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    input  ex_pkg::fu_data_t                  fu_data_i,
    input  logic [isa_pkg::XLen-1:0]          pc_i,
    input  logic                              is_compressed_i,
    input  logic                              alu_valid_i,
    input  logic                              branch_valid_i,
    input  logic                              csr_valid_i,
    input  logic                              mult_valid_i,
    input  logic                              csr_commit_i,
    input  ex_pkg::branch_predict_t           branch_predict_i,
    output ex_pkg::flu_wb_t                   flu_wb_o,
    output logic                              flu_ready_o,
    output ex_pkg::bp_resolve_t               resolved_branch_o,
    output logic [isa_pkg::CsrAddrWidth-1:0]  csr_addr_o
);

    ex_pkg::fu_data_t                alu_data;
    ex_pkg::fu_data_t                mult_data;
    logic [isa_pkg::XLen-1:0]        alu_result;
    logic                            branch_cmp_res;
    logic [isa_pkg::XLen-1:0]        link_addr;
    logic [isa_pkg::XLen-1:0]        csr_result;
    logic                            csr_ready;
    logic [isa_pkg::XLen-1:0]        mult_result;
    logic                            mult_valid;
    logic [ex_pkg::TransIdBits-1:0]  mult_trans_id;

    // ------------------------------------------------------------------------
    // ALU and branch unit, both combinational
    // ------------------------------------------------------------------------
    // Keep the ALU inputs quiet unless it is actually used
    assign alu_data = (alu_valid_i | branch_valid_i) ? fu_data_i : '0;

    alu i_alu (
        .fu_data_i        ( alu_data       ),
        .result_o         ( alu_result     ),
        .branch_cmp_res_o ( branch_cmp_res )
    );

    // Branch path is timing critical, no silencing here
    branch_unit i_branch_unit (
        .fu_data_i         ( fu_data_i         ),
        .pc_i              ( pc_i              ),
        .is_compressed_i   ( is_compressed_i   ),
        .branch_valid_i    ( branch_valid_i    ),
        .branch_predict_i  ( branch_predict_i  ),
        .branch_cmp_res_i  ( branch_cmp_res    ),
        .link_addr_o       ( link_addr         ),
        .resolved_branch_o ( resolved_branch_o )
    );

    // ------------------------------------------------------------------------
    // CSR buffer and multiplier, both sequential
    // ------------------------------------------------------------------------
    csr_buffer i_csr_buffer (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .flush_i      ( flush_i      ),
        .csr_valid_i  ( csr_valid_i  ),
        .csr_commit_i ( csr_commit_i ),
        .fu_data_i    ( fu_data_i    ),
        .csr_ready_o  ( csr_ready    ),
        .csr_result_o ( csr_result   ),
        .csr_addr_o   ( csr_addr_o   )
    );

    assign mult_data = mult_valid_i ? fu_data_i : '0;

    mult i_mult (
        .clk_i           ( clk_i         ),
        .rst_ni          ( rst_ni        ),
        .flush_i         ( flush_i       ),
        .mult_valid_i    ( mult_valid_i  ),
        .fu_data_i       ( mult_data     ),
        .result_o        ( mult_result   ),
        .mult_valid_o    ( mult_valid    ),
        .mult_trans_id_o ( mult_trans_id )
    );

    // ------------------------------------------------------------------------
    // Write-back merge
    // ------------------------------------------------------------------------
    always_comb begin
        flu_wb_o.valid    = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid;
        // Link address when nothing else claims the port
        flu_wb_o.result   = link_addr;
        flu_wb_o.trans_id = fu_data_i.trans_id;
        if (alu_valid_i) begin
            flu_wb_o.result = alu_result;
        end else if (csr_valid_i) begin
            flu_wb_o.result = csr_result;
        end else if (mult_valid) begin
            flu_wb_o.result   = mult_result;
            flu_wb_o.trans_id = mult_trans_id;
        end
    end

    // Multiplier accepts every cycle, only the CSR buffer stalls
    assign flu_ready_o = csr_ready;

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
    output logic clk_o
);

    // 40 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #20 clk_o = ~clk_o;
        end
    end

endmodule

/* tests/ex_stage_checker.sv */
`timescale 1ns/10ps

module ex_stage_checker (
    input logic                              clk_i,
    input logic                              rst_ni,
    input logic                              flush_i,
    input logic                              mult_valid_i,
    input ex_pkg::flu_wb_t                   flu_wb_i,
    input logic                              flu_ready_i,
    input logic [isa_pkg::CsrAddrWidth-1:0]  csr_addr_i
);

    // Set by any assertion failure below
    logic assert_failed;

    initial begin
        assert_failed = 1'b0;
    end

    // No write-back while held in reset
    wb_idle_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !flu_wb_i.valid)
        else begin
            $error("write-back valid during reset");
            assert_failed = 1'b1;
        end

    // Full buffer keeps its address until commit or flush
    csr_addr_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !flu_ready_i |=> $stable(csr_addr_i))
        else begin
            $error("CSR address changed while the buffer was full");
            assert_failed = 1'b1;
        end

    // Product comes back one cycle later
    mult_wb_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mult_valid_i && !flush_i) |=> (flush_i || flu_wb_i.valid))
        else begin
            $error("multiplier write-back missing one cycle after issue");
            assert_failed = 1'b1;
        end

endmodule

bind ex_stage ex_stage_checker i_ex_stage_checker (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .flush_i      ( flush_i      ),
    .mult_valid_i ( mult_valid_i ),
    .flu_wb_i     ( flu_wb_o     ),
    .flu_ready_i  ( flu_ready_o  ),
    .csr_addr_i   ( csr_addr_o   )
);

/* tests/ex_stage_tb.sv */
`timescale 1ns/10ps

module ex_stage_tb;

    // Cycles a wait may take before the run is stopped
    localparam int unsigned CycleTimeout = 16;

    // Numeric columns of one line in the cases file
    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] tid;
        logic [31:0] pc;
        logic [31:0] comp;
        logic [31:0] ptaken;
        logic [31:0] paddr;
        logic [31:0] result;
        logic [31:0] taken;
        logic [31:0] misp;
        logic [31:0] target;
    } case_t;

    logic                              clk_i;
    logic                              rst_ni;
    logic                              flush_i;
    ex_pkg::fu_data_t                  fu_data_i;
    logic [isa_pkg::XLen-1:0]          pc_i;
    logic                              is_compressed_i;
    logic                              alu_valid_i;
    logic                              branch_valid_i;
    logic                              csr_valid_i;
    logic                              mult_valid_i;
    logic                              csr_commit_i;
    ex_pkg::branch_predict_t           branch_predict_i;
    ex_pkg::flu_wb_t                   flu_wb_o;
    logic                              flu_ready_o;
    ex_pkg::bp_resolve_t               resolved_branch_o;
    logic [isa_pkg::CsrAddrWidth-1:0]  csr_addr_o;

    string        c_unit;
    string        c_op_name;
    case_t        cs;
    logic         mult_pending;
    logic [31:0]  pend_result;
    logic [31:0]  pend_tid;

    tb_clock i_tb_clock (
        .clk_o ( clk_i )
    );

    ex_stage DUT (.*);

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, actual, expected);
            stop_with_failure("A result check failed");
        end
    endtask

    // Protocol assertions of the bound checker
    always @(posedge DUT.i_ex_stage_checker.assert_failed) begin
        stop_with_failure("A concurrent assertion in ex_stage_checker failed");
    end

    // Inputs change 2 ns after the rising edge and strobes last one cycle
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
        alu_valid_i    = 1'b0;
        branch_valid_i = 1'b0;
        csr_valid_i    = 1'b0;
        mult_valid_i   = 1'b0;
        csr_commit_i   = 1'b0;
        flush_i        = 1'b0;
    endtask

    task automatic wait_ready();
        int unsigned cycles;
        cycles = 0;
        while (!flu_ready_o) begin
            if (cycles == CycleTimeout) begin
                stop_with_failure("Timeout: flu_ready_o did not return high");
            end
            next_cycle();
            cycles++;
        end
    endtask

    // Idle cycle that collects the last product
    task automatic drain_mult();
        next_cycle();
        @(negedge clk_i);
        check_value(flu_wb_o.valid, 1'b1, "multiplier write-back valid");
        check_value(flu_wb_o.result, pend_result, "multiplier result");
        check_value(flu_wb_o.trans_id, pend_tid, "multiplier trans_id");
        mult_pending = 1'b0;
    endtask

    function automatic isa_pkg::fu_op_e op_from_name(input string name);
        isa_pkg::fu_op_e op;
        op = op.first();
        for (int i = 0; i < op.num(); i++) begin
            if (op.name() == name) begin
                return op;
            end
            op = op.next();
        end
        return op.first();
    endfunction

    task automatic csr_hold_and_release();
        repeat (2) begin
            next_cycle();
            @(negedge clk_i);
            check_value(flu_ready_o, 1'b0, "flu_ready_o while the CSR buffer is full");
            check_value(csr_addr_o, cs.b[isa_pkg::CsrAddrWidth-1:0], "csr_addr_o");
        end
        next_cycle();
        if (c_unit == "C") begin
            csr_commit_i = 1'b1;
        end else begin
            flush_i = 1'b1;
        end
        @(negedge clk_i);
        check_value(flu_ready_o, 1'b0, "flu_ready_o in the release cycle");
        wait_ready();
    endtask

    task automatic run_case();
        isa_pkg::fu_op_e op;
        op = op_from_name(c_op_name);
        if (op.name() != c_op_name) begin
            stop_with_failure({"Unknown operation in the cases file: ", c_op_name});
        end
        if (mult_pending && c_unit != "M") begin
            drain_mult();
        end
        next_cycle();
        wait_ready();
        fu_data_i.operation = op;
        fu_data_i.operand_a = cs.a;
        fu_data_i.operand_b = cs.b;
        fu_data_i.imm       = cs.imm;
        fu_data_i.trans_id  = cs.tid[ex_pkg::TransIdBits-1:0];
        pc_i                = cs.pc;
        is_compressed_i     = cs.comp[0];
        branch_predict_i.cf_taken        = cs.ptaken[0];
        branch_predict_i.predict_address = cs.paddr;
        case (c_unit)
            "A":      alu_valid_i = 1'b1;
            "B":      branch_valid_i = 1'b1;
            "C", "F": csr_valid_i = 1'b1;
            "M", "X": mult_valid_i = 1'b1;
            default:  stop_with_failure({"Unknown unit in the cases file: ", c_unit});
        endcase
        @(negedge clk_i);
        if (c_unit == "M" || c_unit == "X") begin
            // Port shows the previous product when one is pending
            if (mult_pending) begin
                check_value(flu_wb_o.valid, 1'b1, "back-to-back write-back valid");
                check_value(flu_wb_o.result, pend_result, "multiplier result");
                check_value(flu_wb_o.trans_id, pend_tid, "multiplier trans_id");
            end else begin
                check_value(flu_wb_o.valid, 1'b0, "write-back valid in the issue cycle");
            end
        end else begin
            check_value(flu_wb_o.valid, 1'b1, "write-back valid");
            check_value(flu_wb_o.result, cs.result, {c_op_name, " result"});
            check_value(flu_wb_o.trans_id, cs.tid, {c_op_name, " trans_id"});
        end
        if (c_unit == "B") begin
            check_value(resolved_branch_o.valid, 1'b1, "resolved branch valid");
            check_value(resolved_branch_o.pc, cs.pc, "resolved branch pc");
            check_value(resolved_branch_o.target_address, cs.target, "branch target");
            check_value(resolved_branch_o.is_taken, cs.taken, "branch taken");
            check_value(resolved_branch_o.is_mispredict, cs.misp, "branch mispredict");
        end else if (c_unit == "C" || c_unit == "F") begin
            csr_hold_and_release();
        end else if (c_unit == "M") begin
            mult_pending = 1'b1;
            pend_result  = cs.result;
            pend_tid     = cs.tid;
        end else if (c_unit == "X") begin
            next_cycle();
            flush_i = 1'b1;
            @(negedge clk_i);
            check_value(flu_wb_o.valid, 1'b0, "write-back of a flushed multiplication");
        end
    endtask

    initial begin
        string line;
        int    fd;
        int    fields;
        rst_ni           = 1'b0;
        flush_i          = 1'b0;
        fu_data_i        = '0;
        pc_i             = '0;
        is_compressed_i  = 1'b0;
        alu_valid_i      = 1'b0;
        branch_valid_i   = 1'b0;
        csr_valid_i      = 1'b0;
        mult_valid_i     = 1'b0;
        csr_commit_i     = 1'b0;
        branch_predict_i = '0;
        mult_pending     = 1'b0;
        fd = $fopen("tests/ex_cases.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Cannot open tests/ex_cases.txt");
        end
        repeat (3) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_value(flu_wb_o.valid, 1'b0, "write-back valid after reset");
        check_value(resolved_branch_o.valid, 1'b0, "resolved branch valid after reset");
        check_value(flu_ready_o, 1'b1, "flu_ready_o after reset");
        check_value(csr_addr_o, '0, "csr_addr_o after reset");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h",
                    c_unit, c_op_name, cs.a, cs.b, cs.imm, cs.tid, cs.pc, cs.comp,
                    cs.ptaken, cs.paddr, cs.result, cs.taken, cs.misp, cs.target);
                if (fields != 14) begin
                    stop_with_failure({"Malformed line in the cases file: ", line});
                end
                run_case();
            end
        end
        $fclose(fd);
        if (mult_pending) begin
            drain_mult();
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* tests/ex_cases.txt */
# unit op a b imm trans_id pc compressed pred_taken pred_addr result taken mispredict target
# units: A alu, B branch, C csr then commit, F csr then flush, M mult, X mult then flush
A ADD       00000005 00000007 00000000 1 00000000 0 0 00000000 0000000c 0 0 00000000
A SUB       00000003 00000005 00000000 2 00000000 0 0 00000000 fffffffe 0 0 00000000
A AND       f0f0f0f0 0ff00ff0 00000000 3 00000000 0 0 00000000 00f000f0 0 0 00000000
A OR        12340000 00005678 00000000 4 00000000 0 0 00000000 12345678 0 0 00000000
A XOR       ffff0000 0f0f0f0f 00000000 5 00000000 0 0 00000000 f0f00f0f 0 0 00000000
A SLL       00000001 0000001f 00000000 6 00000000 0 0 00000000 80000000 0 0 00000000
A SRL       80000000 00000004 00000000 7 00000000 0 0 00000000 08000000 0 0 00000000
A SRA       80000000 00000004 00000000 0 00000000 0 0 00000000 f8000000 0 0 00000000
A SLTS      ffffffff 00000001 00000000 1 00000000 0 0 00000000 00000001 0 0 00000000
A SLTU      ffffffff 00000001 00000000 2 00000000 0 0 00000000 00000000 0 0 00000000
B EQ        00000005 00000005 00000010 3 00001000 0 1 00001010 00001004 1 0 00001010
B LTS       fffffff0 00000001 00000020 4 00002000 1 0 00000000 00002002 1 1 00002020
B GEU       00000001 00000002 00000040 5 00003000 0 0 00000000 00003004 0 0 00003004
B JAL       00000000 00000000 00000100 6 00004000 0 1 00004200 00004004 1 1 00004100
B JALR      00005001 00000000 00000010 7 00005000 1 1 00005010 00005002 1 0 00005010
C CSR_WRITE deadbeef 00000305 00000000 1 00000000 0 0 00000000 deadbeef 0 0 00000000
F CSR_READ  00000042 0000f341 00000000 2 00000000 0 0 00000000 00000042 0 0 00000000
M MUL       00001234 00005678 00000000 2 00000000 0 0 00000000 06260060 0 0 00000000
M MULH      ffffffff 00000002 00000000 3 00000000 0 0 00000000 ffffffff 0 0 00000000
M MULHU     ffffffff 00000002 00000000 4 00000000 0 0 00000000 00000001 0 0 00000000
X MUL       00000003 00000003 00000000 5 00000000 0 0 00000000 00000009 0 0 00000000
A ADD       7fffffff 00000001 00000000 6 00000000 0 0 00000000 80000000 0 0 00000000

/* tb.f */
source/isa_pkg.sv
source/ex_pkg.sv
source/alu.sv
source/branch_unit.sv
source/csr_buffer.sv
source/mult.sv
source/ex_stage.sv
tests/tb_clock.sv
tests/ex_stage_checker.sv
tests/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - files:
      - source/isa_pkg.sv
      - source/ex_pkg.sv
      - source/alu.sv
      - source/branch_unit.sv
      - source/csr_buffer.sv
      - source/mult.sv
      - source/ex_stage.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/ex_stage_checker.sv
      - tests/ex_stage_tb.sv
